/* Bender.yml */
package:
  name: ctrl_nmi_fencei

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/bus_pkg.sv
      - hw/ctrl_pkg.sv
      - hw/data_obs_if.sv
      - hw/lsu_outstanding_tracker.sv
      - hw/bus_error_nmi.sv
      - hw/fencei_flush_ctrl.sv
      - hw/ctrl_nmi_fencei_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_top.sv

/* bench/tb_top.sv */
// Drives in-order data-bus traffic and fence.i handshakes; at most MAX_OUTSTANDING in flight

`default_nettype none

`include "ctrl_params.svh"

module tb_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES  = 4000;
  localparam int N_SCENARIOS = 20;

  logic clk;
  logic rst_n;
  logic data_req_i;
  logic data_gnt_i;
  logic data_we_i;
  logic data_rvalid_i;
  logic data_err_i;
  logic fencei_in_wb_i;
  logic fencei_ready_i;
  logic fencei_flush_ack_i;
  logic fencei_flush_req_o;
  logic fencei_done_o;
  logic nmi_pending_o;
  logic nmi_is_store_o;
  logic nmi_take_o;

  // Reference model of the transfers in flight, oldest at the front
  logic   model_q[$];
  int     model_cnt;
  logic   model_oldest;
  // Request of the previous cycle, high in the cycle after the ack too
  logic   flush_req_d;
  logic   fencei_start;
  integer seed;
  int     error_count;
  int     cycle_count;

  ctrl_nmi_fencei_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Ends a run that hangs, for example on a request that never rises
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  // A response retires the oldest transfer before the new one is queued
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_q.delete();
      model_cnt    = 0;
      model_oldest = 1'b0;
    end else begin
      if (data_rvalid_i && (model_q.size() != 0)) begin
        void'(model_q.pop_front());
      end
      if (data_req_i && data_gnt_i) begin
        model_q.push_back(data_we_i);
      end
      model_cnt    = model_q.size();
      model_oldest = (model_q.size() != 0) ? model_q[0] : 1'b0;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_req_d <= 1'b0;
    end else begin
      flush_req_d <= fencei_flush_req_o;
    end
  end

  // fence.i may start only while no NMI waits
  assign fencei_start = fencei_in_wb_i && fencei_ready_i && !nmi_pending_o;

  task automatic report_error(input string msg);
    error_count++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////

  a_reset_values :
    assert property (@(posedge clk) $rose(rst_n) |->
                     !(fencei_flush_req_o || fencei_done_o || nmi_pending_o ||
                       nmi_take_o || nmi_is_store_o))
      else report_error("an output is high after reset");

  a_error_latch :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (data_rvalid_i && data_err_i && !nmi_pending_o) |=>
                     nmi_pending_o && (nmi_is_store_o == $past(model_oldest)))
      else report_error("first bus error not latched with the oldest type");

  a_later_error :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (data_rvalid_i && data_err_i && nmi_pending_o) |=>
                     nmi_pending_o && $stable(nmi_is_store_o))
      else report_error("later bus error changed the NMI state");

  a_take :
    assert property (@(posedge clk) disable iff (!rst_n)
                     nmi_take_o |->
                     (nmi_pending_o && (model_cnt == 0) && !fencei_flush_req_o &&
                      !flush_req_d) ##1 !nmi_pending_o)
      else report_error("NMI taken while busy or not cleared");

  a_fencei_start :
    assert property (@(posedge clk) disable iff (!rst_n)
                     ($rose(fencei_start) && !fencei_flush_req_o && !flush_req_d) |=>
                     !fencei_flush_req_o ##1 fencei_flush_req_o)
      else report_error("flush request not raised two cycles after start");

  a_fencei_hold :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (fencei_flush_req_o && !fencei_flush_ack_i) |=> fencei_flush_req_o)
      else report_error("flush request dropped before the ack");

  a_fencei_clear :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (fencei_flush_req_o && fencei_flush_ack_i) |=> !fencei_flush_req_o)
      else report_error("flush request still high after the ack");

  a_fencei_done :
    assert property (@(posedge clk) disable iff (!rst_n)
                     $fell(fencei_flush_req_o) |=> fencei_done_o ##1 !fencei_done_o)
      else report_error("done strobe missing or too long");

  a_fencei_blocked :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (nmi_pending_o && $rose(fencei_in_wb_i) && !fencei_flush_req_o &&
                      !flush_req_d) |=> !fencei_flush_req_o ##1 !fencei_flush_req_o)
      else report_error("flush request raised under a pending NMI");

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the edge, each call lasts one cycle
  task automatic drive_bus_cycle(input logic req, input logic gnt, input logic we,
                                 input logic rsp, input logic err);
    data_req_i    = req;
    data_gnt_i    = gnt;
    data_we_i     = we;
    data_rvalid_i = rsp;
    data_err_i    = err;
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_bus_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // Grant is withheld at the limit unless a response frees a slot
  task automatic random_traffic(input int n_cycles, input logic with_err);
    logic [31:0] r;
    logic        gnt;
    logic        rsp;
    for (int i = 0; i < n_cycles; i++) begin
      r   = $random(seed);
      rsp = r[3] && (model_cnt != 0);
      gnt = r[1] | r[2];
      if ((model_cnt == `MAX_OUTSTANDING) && !rsp) begin
        gnt = 1'b0;
      end
      drive_bus_cycle(r[0], gnt, r[8], rsp, with_err && rsp && (r[6:4] == 3'd0));
    end
  endtask

  task automatic drain_bus();
    while (model_cnt != 0) begin
      drive_bus_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    end
    idle_cycles(1);
  endtask

  // Callers make sure the bus is empty so the take can happen
  task automatic clear_nmi();
    while (nmi_pending_o) begin
      idle_cycles(1);
    end
  endtask

  // Two transfers in flight, then an error on each response
  task automatic error_pair();
    logic [31:0] r;
    r = $random(seed);
    drive_bus_cycle(1'b1, 1'b1, r[0], 1'b0, 1'b0);
    drive_bus_cycle(1'b1, 1'b1, r[1], 1'b0, 1'b0);
    drive_bus_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
    drive_bus_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
  endtask

  // Ready may come late so that the start is set by its rising edge
  task automatic run_fencei(input int ack_delay, input logic late_ready);
    fencei_ready_i = !late_ready;
    fencei_in_wb_i = 1'b1;
    idle_cycles(2);
    fencei_ready_i = 1'b1;
    while (!fencei_flush_req_o) begin
      idle_cycles(1);
    end
    idle_cycles(ack_delay);
    fencei_flush_ack_i = 1'b1;
    idle_cycles(1);
    fencei_flush_ack_i = 1'b0;
    while (!fencei_done_o) begin
      idle_cycles(1);
    end
    fencei_in_wb_i = 1'b0;
    idle_cycles(1);
  endtask

  initial begin
    logic [31:0] r;
    seed               = 85;
    error_count        = 0;
    rst_n              = 1'b0;
    data_req_i         = 1'b0;
    data_gnt_i         = 1'b0;
    data_we_i          = 1'b0;
    data_rvalid_i      = 1'b0;
    data_err_i         = 1'b0;
    fencei_in_wb_i     = 1'b0;
    fencei_ready_i     = 1'b1;
    fencei_flush_ack_i = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    idle_cycles(2);
    for (int sc = 0; sc < N_SCENARIOS; sc++) begin
      r = $random(seed);
      case (sc % 4)
        0: begin
          random_traffic(40, 1'b0);
          drain_bus();
          run_fencei(r[2:0] % 6, r[3]);
        end
        1: begin
          random_traffic(30, 1'b1);
          drain_bus();
          clear_nmi();
          error_pair();
        end
        2: begin
          // One transfer stays in flight so the NMI cannot be taken yet
          drive_bus_cycle(1'b1, 1'b1, r[0], 1'b0, 1'b0);
          drive_bus_cycle(1'b1, 1'b1, r[1], 1'b0, 1'b0);
          drive_bus_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
          fencei_in_wb_i = 1'b1;
          idle_cycles(5);
          fencei_in_wb_i = 1'b0;
          drain_bus();
        end
        default: begin
          // The error lands while the flush waits for its ack
          fencei_in_wb_i = 1'b1;
          drive_bus_cycle(1'b1, 1'b1, r[0], 1'b0, 1'b0);
          drive_bus_cycle(1'b1, 1'b1, r[1], 1'b0, 1'b0);
          while (!fencei_flush_req_o) begin
            idle_cycles(1);
          end
          drive_bus_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
          drive_bus_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
          idle_cycles(3);
          fencei_flush_ack_i = 1'b1;
          idle_cycles(1);
          fencei_flush_ack_i = 1'b0;
          // The fence.i leaves writeback with the done strobe, before the NMI clears
          while (!fencei_done_o) begin
            idle_cycles(1);
          end
          fencei_in_wb_i = 1'b0;
          idle_cycles(3);
        end
      endcase
      clear_nmi();
      idle_cycles(2);
    end
    $display("Run complete: %0d scenarios, %0d cycles, %0d errors",
             N_SCENARIOS, cycle_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/bus_error_nmi.sv */
// Only the first data bus error is kept; later errors are dropped until the NMI is taken

`default_nettype none

module bus_error_nmi (
  input  logic                clk,
  input  logic                rst_n,
  data_obs_if.error           obs,
  input  bus_pkg::out_cnt_t   out_cnt_i,
  input  bus_pkg::xfer_type_e rsp_type_i,
  input  logic                flush_busy_i,
  output logic                nmi_pending_o,
  output logic                nmi_is_store_o,
  output logic                nmi_take_o
);

  import bus_pkg::*;
  import ctrl_pkg::*;

  nmi_state_e state_q;
  logic       is_store_q;
  logic       err_rsp;
  logic       bus_idle;

  assign err_rsp  = obs.rvalid && obs.err;
  assign bus_idle = (out_cnt_i == '0);

  // The NMI waits for the data bus to drain and for any fence.i flush
  // to finish, so no transfer is lost when the handler starts
  assign nmi_take_o = (state_q == NMI_PENDING) && bus_idle && !flush_busy_i;

  //////////////////////////////////////////////////////////////////////
  // Pending NMI state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= NMI_IDLE;
      is_store_q <= 1'b0;
    end else begin
      case (state_q)
        NMI_IDLE: begin
          // The store flag keeps its value after the take, like a cause register
          if (err_rsp) begin
            state_q    <= NMI_PENDING;
            is_store_q <= (rsp_type_i == XFER_STORE);
          end
        end
        NMI_PENDING: begin
          if (nmi_take_o) begin
            state_q <= NMI_IDLE;
          end
        end
        default: state_q <= NMI_IDLE;
      endcase
    end
  end

  assign nmi_pending_o  = (state_q == NMI_PENDING);
  assign nmi_is_store_o = is_store_q;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // The first error must be latched with the type the tracker reported
  a_latched_bus_error :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (err_rsp && !nmi_pending_o)
                     |=> nmi_pending_o &&
                         (nmi_is_store_o == $past(rsp_type_i == XFER_STORE)))
      else $error("Bus error latched with the wrong type");

  // Taking the NMI needs an empty bus and clears the pending flag
  a_take_when_idle :
    assert property (@(posedge clk) disable iff (!rst_n)
                     nmi_take_o |-> (out_cnt_i == '0) ##1 !nmi_pending_o)
      else $error("NMI taken with outstanding transfers");

endmodule

`default_nettype wire

/* hw/bus_pkg.sv */
// Data-bus types; the count type is sized by OUT_CNT_W from the parameter header

`default_nettype none

`include "ctrl_params.svh"

package bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Transfer classification
  //////////////////////////////////////////////////////////////////////

  // Type of a data transfer, taken straight from the write enable
  // A write is a store and a read is a load
  typedef enum logic {
    XFER_LOAD  = 1'b0,
    XFER_STORE = 1'b1
  } xfer_type_e;

  //////////////////////////////////////////////////////////////////////
  // Outstanding accounting
  //////////////////////////////////////////////////////////////////////

  // Number of accepted transfers still waiting for their response
  typedef logic [`OUT_CNT_W-1:0] out_cnt_t;

endpackage

`default_nettype wire

/* hw/ctrl_nmi_fencei_top.sv */
// Controller slice top; data bus inputs are observed only and must follow in-order responses

`default_nettype none

module ctrl_nmi_fencei_top (
  input  logic clk,
  input  logic rst_n,
  // Observed data bus
  input  logic data_req_i,
  input  logic data_gnt_i,
  input  logic data_we_i,
  input  logic data_rvalid_i,
  input  logic data_err_i,
  // fence.i handshake with the instruction cache
  input  logic fencei_in_wb_i,
  input  logic fencei_ready_i,
  input  logic fencei_flush_ack_i,
  output logic fencei_flush_req_o,
  output logic fencei_done_o,
  // NMI status
  output logic nmi_pending_o,
  output logic nmi_is_store_o,
  output logic nmi_take_o
);

  import bus_pkg::*;

  out_cnt_t   out_cnt;
  xfer_type_e rsp_type;
  logic       nmi_pending;
  logic       flush_busy;

  //////////////////////////////////////////////////////////////////////
  // Data bus bundle
  //////////////////////////////////////////////////////////////////////

  data_obs_if obs_if ();

  assign obs_if.req    = data_req_i;
  assign obs_if.gnt    = data_gnt_i;
  assign obs_if.we     = data_we_i;
  assign obs_if.rvalid = data_rvalid_i;
  assign obs_if.err    = data_err_i;

  //////////////////////////////////////////////////////////////////////
  // Peers
  //////////////////////////////////////////////////////////////////////

  lsu_outstanding_tracker u_tracker (
    .clk        (clk),
    .rst_n      (rst_n),
    .obs        (obs_if.monitor),
    .out_cnt_o  (out_cnt),
    .rsp_type_o (rsp_type)
  );

  bus_error_nmi u_nmi (
    .clk            (clk),
    .rst_n          (rst_n),
    .obs            (obs_if.error),
    .out_cnt_i      (out_cnt),
    .rsp_type_i     (rsp_type),
    .flush_busy_i   (flush_busy),
    .nmi_pending_o  (nmi_pending),
    .nmi_is_store_o (nmi_is_store_o),
    .nmi_take_o     (nmi_take_o)
  );

  fencei_flush_ctrl u_fencei (
    .clk            (clk),
    .rst_n          (rst_n),
    .fencei_in_wb_i (fencei_in_wb_i),
    .fencei_ready_i (fencei_ready_i),
    .nmi_pending_i  (nmi_pending),
    .flush_ack_i    (fencei_flush_ack_i),
    .flush_req_o    (fencei_flush_req_o),
    .flush_done_o   (fencei_done_o),
    .flush_busy_o   (flush_busy)
  );

  assign nmi_pending_o = nmi_pending;

endmodule

`default_nettype wire

/* hw/ctrl_params.svh */
// Sizing for the data-bus tracker, which assumes at most two data transfers in flight at once

`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Outstanding transaction limits
//////////////////////////////////////////////////////////////////////

// Most data transfers the core may have in flight at the same time
// The LSU never issues a third request before the first response returns
`define MAX_OUTSTANDING 2

// Width of the outstanding counter
// Two bits are enough to hold the values zero to MAX_OUTSTANDING
`define OUT_CNT_W 2

// The type queue in the tracker is written out for exactly
// MAX_OUTSTANDING entries, so both values move together

`endif

/* hw/ctrl_pkg.sv */
// Controller state encodings for the fence.i handshake and the bus-error NMI

`default_nettype none

package ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // fence.i flush handshake
  //////////////////////////////////////////////////////////////////////

  // IDLE waits for a fence.i in writeback
  // REQ drives the flush request to the instruction cache until acked
  // DONE is the cycle after the ack, before the completion strobe
  typedef enum logic [1:0] {
    FENCEI_IDLE = 2'b00,
    FENCEI_REQ  = 2'b01,
    FENCEI_DONE = 2'b10
  } fencei_state_e;

  //////////////////////////////////////////////////////////////////////
  // Non-maskable interrupt
  //////////////////////////////////////////////////////////////////////

  // PENDING holds a latched bus error until the NMI is taken
  typedef enum logic {
    NMI_IDLE    = 1'b0,
    NMI_PENDING = 1'b1
  } nmi_state_e;

endpackage

`default_nettype wire

/* hw/data_obs_if.sv */
// Observation-only view of the core data bus; nothing here drives the bus itself

`default_nettype none

interface data_obs_if;

  // Request phase
  logic req;
  logic gnt;
  logic we;

  // Response phase
  logic rvalid;
  logic err;

  // The tracker follows both phases but has no use for the error flag
  modport monitor (
    input req,
    input gnt,
    input we,
    input rvalid
  );

  // The NMI logic only looks at responses
  modport error (
    input rvalid,
    input err
  );

  // The top level copies its plain ports onto the bundle
  modport source (
    output req,
    output gnt,
    output we,
    output rvalid,
    output err
  );

endinterface

`default_nettype wire

/* hw/fencei_flush_ctrl.sv */
// fence.i flush handshake; the instruction cache may hold the ack low for any number of cycles

`default_nettype none

module fencei_flush_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic fencei_in_wb_i,
  input  logic fencei_ready_i,
  input  logic nmi_pending_i,
  input  logic flush_ack_i,
  output logic flush_req_o,
  output logic flush_done_o,
  output logic flush_busy_o
);

  import ctrl_pkg::*;

  fencei_state_e state_q;
  logic          start;
  logic          start_d_q;
  logic          go_q;
  logic          done_q;

  // A pending NMI has priority, so the flush may not start under it
  assign start = fencei_in_wb_i && fencei_ready_i && !nmi_pending_i;

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_d_q <= 1'b0;
      go_q      <= 1'b0;
      done_q    <= 1'b0;
      state_q   <= FENCEI_IDLE;
    end else begin
      // Only the rising edge starts a flush, one per fence.i
      start_d_q <= start;
      go_q      <= start && !start_d_q;
      // Completion is flagged the cycle after the ack has been consumed
      done_q    <= (state_q == FENCEI_DONE);
      case (state_q)
        FENCEI_IDLE: begin
          if (go_q) begin
            state_q <= FENCEI_REQ;
          end
        end
        FENCEI_REQ: begin
          if (flush_ack_i) begin
            state_q <= FENCEI_DONE;
          end
        end
        FENCEI_DONE: state_q <= FENCEI_IDLE;
        default:     state_q <= FENCEI_IDLE;
      endcase
    end
  end

  assign flush_req_o  = (state_q == FENCEI_REQ);
  assign flush_done_o = done_q;
  assign flush_busy_o = (state_q != FENCEI_IDLE);

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // The request is held until the instruction cache acknowledges it
  a_req_clear_after_ack :
    assert property (@(posedge clk) disable iff (!rst_n)
                     $fell(flush_req_o) |-> $past(flush_ack_i))
      else $error("fence.i request dropped without an ack");

  a_req_gone_after_ack :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (flush_req_o && flush_ack_i) |=> !flush_req_o)
      else $error("fence.i request still high after req and ack");

  // The write buffer must stay empty for the whole handshake
  a_req_needs_ready :
    assert property (@(posedge clk) disable iff (!rst_n)
                     flush_req_o |-> fencei_ready_i)
      else $error("fence.i request while not ready");

endmodule

`default_nettype wire

/* hw/lsu_outstanding_tracker.sv */
// Tracks up to MAX_OUTSTANDING data transfers; responses must return in order

`default_nettype none

`include "ctrl_params.svh"

module lsu_outstanding_tracker (
  input  logic                clk,
  input  logic                rst_n,
  data_obs_if.monitor         obs,
  output bus_pkg::out_cnt_t   out_cnt_o,
  output bus_pkg::xfer_type_e rsp_type_o
);

  import bus_pkg::*;

  // Entry 0 holds the newest transfer, entry 1 the older one
  out_cnt_t   cnt_q;
  xfer_type_e type_q [`MAX_OUTSTANDING];
  logic       accept;
  logic       respond;
  logic       shift;

  assign accept  = obs.req && obs.gnt;
  assign respond = obs.rvalid;

  //////////////////////////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////////////////////////

  // A transfer and a response in the same cycle cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (accept && !respond) begin
      cnt_q <= cnt_q + out_cnt_t'(1);
    end else if (!accept && respond) begin
      cnt_q <= cnt_q - out_cnt_t'(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Type queue
  //////////////////////////////////////////////////////////////////////

  // The older entry must survive when a new transfer comes in and
  // something is still left over after this cycle's response
  // With one outstanding and a response, the old entry leaves anyway
  assign shift = (!respond && (cnt_q != '0)) ||
                 (respond && (cnt_q == out_cnt_t'(`MAX_OUTSTANDING)));

  always_ff @(posedge clk) begin
    if (accept) begin
      type_q[0] <= xfer_type_e'(obs.we);
      if (shift) begin
        type_q[1] <= type_q[0];
      end
    end
  end

  // The response always answers the oldest accepted transfer
  assign rsp_type_o = (cnt_q == out_cnt_t'(`MAX_OUTSTANDING)) ? type_q[1] : type_q[0];
  assign out_cnt_o  = cnt_q;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // The LSU must stop requesting once the limit is reached
  a_cnt_limit :
    assert property (@(posedge clk) disable iff (!rst_n)
                     cnt_q <= out_cnt_t'(`MAX_OUTSTANDING))
      else $error("Outstanding count above the limit");

  // A response with nothing in flight would underflow the counter
  a_no_orphan_rsp :
    assert property (@(posedge clk) disable iff (!rst_n)
                     obs.rvalid |-> (cnt_q != '0))
      else $error("Response with no outstanding transfer");

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
hw/bus_pkg.sv
hw/ctrl_pkg.sv
hw/data_obs_if.sv
hw/lsu_outstanding_tracker.sv
hw/bus_error_nmi.sv
hw/fencei_flush_ctrl.sv
hw/ctrl_nmi_fencei_top.sv
bench/tb_top.sv
